// File: tb.f
verilog/read_path_pkg.sv
verilog/read_latency_fifo.sv
verilog/group_read_fifo.sv
verilog/read_data_align.sv
verilog/oct_control.sv
verilog/read_datapath.sv
bench/read_datapath_assert.sv
bench/read_datapath_tb.sv

// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TOP        := read_datapath_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := RESULT: FAIL
PASS_MSG   := RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails on the fail message, or when no result line was printed at all
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/read_datapath_tb.sv
/*
 * Read datapath testbench
 * Directed tests for latency alignment, group merge, FIFO reset and termination
 */

`timescale 1ns/100ps
`default_nettype none

module read_datapath_tb;

	// DUT runs with its default parameters
	localparam int EXTRA_SHIFT      = 1;
	localparam int MAX_READ_LATENCY = 16;
	localparam int MEM_T_RL         = 11;
	localparam int OCT_ON_DELAY     = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 4) : 0;
	localparam int OCT_OFF_DELAY    = (MEM_T_RL + 8) / 4;

	logic                       pll_afi_clk;
	logic                       reset_n_afi_clk;
	logic                       rdata_en;
	read_path_pkg::lat_count_t  latency;
	read_path_pkg::group_mask_t fifo_reset;
	read_path_pkg::group_mask_t capture_valid;
	read_path_pkg::afi_data_t   capture_data;
	read_path_pkg::afi_data_t   afi_rdata;
	read_path_pkg::afi_data_t   seq_rdata;
	logic                       afi_rdata_valid;
	logic                       force_oct_off;

	// Count of rising clock edges, the interval after edge k is cycle k
	int unsigned cyc = 0;
	int          error_count = 0;
	int          check_count = 0;
	integer      seed;

	// Reference queue of outstanding reads, the due cycle and the capture word
	int unsigned              exp_cycle [$];
	read_path_pkg::afi_data_t exp_word [$];

	read_datapath read_datapath_i (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.rdata_en_i                 (rdata_en),
		.seq_read_latency_counter_i (latency),
		.seq_read_fifo_reset_i      (fifo_reset),
		.capture_valid_i            (capture_valid),
		.capture_data_i             (capture_data),
		.afi_rdata_o                (afi_rdata),
		.seq_rdata_o                (seq_rdata),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.force_oct_off_o            (force_oct_off)
	);

	initial begin
		pll_afi_clk = 1'b0;
		forever #2 pll_afi_clk = ~pll_afi_clk;
	end

	always @(posedge pll_afi_clk) begin
		cyc <= cyc + 1;
	end

	// ************************************************************
	// Reference model and helpers
	// ************************************************************

	// Group order puts group g at bit 16g, slot order puts slot t, group g at 16t+8g
	function automatic read_path_pkg::afi_data_t slot_order(input read_path_pkg::afi_data_t word);
		read_path_pkg::afi_data_t result;
		for (int g = 0; g < read_path_pkg::NUM_GROUPS; g++) begin
			for (int t = 0; t < read_path_pkg::SLOTS_PER_BEAT; t++) begin
				result[t*16 + g*8 +: 8] = word[g*16 + t*8 +: 8];
			end
		end
		return result;
	endfunction

	task automatic compare_hex(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		assert (got === expected) else begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	// Inputs change 1 ns after the rising edge and hold for the whole cycle
	task automatic drive_cycle(input logic en, input read_path_pkg::group_mask_t valid_mask,
			input read_path_pkg::afi_data_t word);
		@(posedge pll_afi_clk);
		#1;
		rdata_en      = en;
		capture_valid = valid_mask;
		capture_data  = word;
	endtask

	// Old enables stay in the latency shifter for MAX_READ_LATENCY cycles
	// A new tap would pick them up again, so the latency only moves once they are gone
	task automatic drain_latency_shifter();
		repeat (MAX_READ_LATENCY + EXTRA_SHIFT + 2) begin
			drive_cycle(1'b0, '0, '0);
		end
	endtask

	// A read issued in cycle N is due in cycle N+E+L+4
	task automatic issue_read(input read_path_pkg::afi_data_t word);
		drive_cycle(1'b1, '0, '0);
		exp_cycle.push_back(cyc + EXTRA_SHIFT + int'(latency) + 4);
		exp_word.push_back(word);
	endtask

	task automatic wait_for_beats(input int limit);
		int waited;
		waited = 0;
		while (exp_cycle.size() != 0 && waited < limit) begin
			drive_cycle(1'b0, '0, '0);
			waited++;
		end
		check_count++;
		assert (exp_cycle.size() == 0) else begin
			$display("Read data did not arrive within %0d cycles", limit);
			error_count++;
		end
	endtask

	// Idle cycles in which read valid must stay low
	task automatic expect_no_valid(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			drive_cycle(1'b0, '0, '0);
			@(negedge pll_afi_clk);
			compare_hex("afi_rdata_valid_o", 32'(afi_rdata_valid), 32'd0);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("Test %s finished with %0d errors", name, error_count - errors_before);
	endtask

	// Every valid beat must match the oldest outstanding read, in cycle and data
	always @(negedge pll_afi_clk) begin : check_read_beats
		int unsigned              due;
		read_path_pkg::afi_data_t word;
		if (reset_n_afi_clk && afi_rdata_valid) begin
			check_count++;
			assert (exp_cycle.size() != 0) else begin
				$display("Read valid arrived with no read outstanding");
				error_count++;
			end
			if (exp_cycle.size() != 0) begin
				due  = exp_cycle.pop_front();
				word = exp_word.pop_front();
				compare_hex("afi_rdata_valid_o cycle", 32'(cyc), 32'(due));
				compare_hex("afi_rdata_o", afi_rdata, slot_order(word));
				compare_hex("seq_rdata_o", seq_rdata, word);
			end
		end
	end

	// ************************************************************
	// Directed tests
	// ************************************************************

	task automatic test_after_reset();
		int errors_before;
		errors_before = error_count;
		repeat (7) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		compare_hex("afi_rdata_valid_o", 32'(afi_rdata_valid), 32'd0);
		compare_hex("force_oct_off_o", 32'(force_oct_off), 32'd0);
		// Release after the eighth edge, then one idle clock raises force-off
		@(posedge pll_afi_clk);
		#1;
		reset_n_afi_clk = 1'b1;
		@(negedge pll_afi_clk);
		compare_hex("afi_rdata_valid_o", 32'(afi_rdata_valid), 32'd0);
		compare_hex("force_oct_off_o", 32'(force_oct_off), 32'd0);
		@(negedge pll_afi_clk);
		compare_hex("force_oct_off_o", 32'(force_oct_off), 32'd1);
		report_test("after_reset", errors_before);
	endtask

	task automatic test_single_read();
		int                       errors_before;
		read_path_pkg::afi_data_t word;
		errors_before = error_count;
		drive_cycle(1'b0, '0, '0);
		latency = 4'd3;
		word = $random(seed);
		drive_cycle(1'b0, 2'b11, word);
		issue_read(word);
		wait_for_beats(40);
		// A second valid cycle would show up here as an unexpected beat
		expect_no_valid(3);
		report_test("single_read", errors_before);
	endtask

	task automatic test_back_to_back();
		int                       errors_before;
		read_path_pkg::afi_data_t words [4];
		errors_before = error_count;
		for (int run = 0; run < 2; run++) begin
			drain_latency_shifter();
			latency = (run == 0) ? 4'd2 : 4'd9;
			for (int i = 0; i < 4; i++) begin
				words[i] = $random(seed);
				drive_cycle(1'b0, 2'b11, words[i]);
			end
			for (int i = 0; i < 4; i++) begin
				issue_read(words[i]);
			end
			wait_for_beats(60);
		end
		report_test("back_to_back", errors_before);
	endtask

	task automatic test_missing_group();
		int                       errors_before;
		read_path_pkg::afi_data_t word;
		errors_before = error_count;
		// Group 1 holds nothing, so the merged beat is never valid
		word = $random(seed);
		drive_cycle(1'b0, 2'b01, word);
		drive_cycle(1'b1, '0, '0);
		expect_no_valid(EXTRA_SHIFT + int'(latency) + 8);
		// Words pending in both FIFOs are thrown away by the sequencer reset
		drive_cycle(1'b0, 2'b11, $random(seed));
		drive_cycle(1'b0, 2'b11, $random(seed));
		drive_cycle(1'b0, '0, '0);
		fifo_reset = 2'b11;
		drive_cycle(1'b0, '0, '0);
		drive_cycle(1'b0, '0, '0);
		fifo_reset = 2'b00;
		drive_cycle(1'b0, '0, '0);
		drive_cycle(1'b1, '0, '0);
		expect_no_valid(EXTRA_SHIFT + int'(latency) + 8);
		report_test("missing_group", errors_before);
	endtask

	task automatic test_termination();
		int         errors_before;
		logic       en_now;
		logic       expected;
		logic [7:0] en_seen;
		errors_before = error_count;
		en_seen = '0;
		// One single enable, then a burst of three
		for (int i = 0; i < 24; i++) begin
			en_now = (i == 2) || (i >= 10 && i <= 12);
			drive_cycle(en_now, '0, '0);
			@(negedge pll_afi_clk);
			// Bit k holds the enable of k cycles back, the output lags by one cycle
			en_seen  = {en_seen[6:0], en_now};
			expected = ~|en_seen[OCT_OFF_DELAY+1:OCT_ON_DELAY+1];
			compare_hex("force_oct_off_o", 32'(force_oct_off), 32'(expected));
		end
		report_test("termination", errors_before);
	endtask

	// ************************************************************
	// Test sequence
	// ************************************************************

	initial begin
		seed            = 32'h48f0_15d8;
		reset_n_afi_clk = 1'b0;
		rdata_en        = 1'b0;
		latency         = '0;
		fifo_reset      = '0;
		capture_valid   = '0;
		capture_data    = '0;
		test_after_reset();
		test_single_read();
		test_back_to_back();
		test_missing_group();
		test_termination();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog for a run that stops making progress
	initial begin
		#20000;
		$display("Simulation timed out");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/read_datapath_assert.sv
/*
 * Read datapath assertions
 * Reset levels, known outputs and read valid tied back to its read enable
 */

`timescale 1ns/100ps
`default_nettype none

module read_datapath_assert #(
	parameter int EXTRA_SHIFT = 1
) (
	input wire                       pll_afi_clk,
	input wire                       reset_n_afi_clk,
	input wire                       rdata_en_i,
	input read_path_pkg::lat_count_t seq_read_latency_counter_i,
	input read_path_pkg::afi_data_t  afi_rdata_o,
	input wire                       afi_rdata_valid_o,
	input wire                       force_oct_off_o
);

	// Enable history, bit k holds the enable sampled k+1 edges back
	logic [23:0] en_hist;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			en_hist <= '0;
		end else begin
			en_hist <= {en_hist[22:0], rdata_en_i};
		end
	end

	// Both registered outputs sit at their reset level
	assert property (@(posedge pll_afi_clk)
			!reset_n_afi_clk |-> !afi_rdata_valid_o && !force_oct_off_o)
		else $error("Read valid or force-off active during reset");

	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			!$isunknown({afi_rdata_valid_o, force_oct_off_o}))
		else $error("Unknown value on read valid or force-off");

	// Data has no reset, so it only has to be known with valid
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			afi_rdata_valid_o |-> !$isunknown(afi_rdata_o))
		else $error("Unknown read data with read valid high");

	// A rising valid needs its enable E+L+4 cycles earlier
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			$rose(afi_rdata_valid_o) |->
			en_hist[int'(seq_read_latency_counter_i) + EXTRA_SHIFT + 3])
		else $error("Read valid rose without a matching read enable");

endmodule

bind read_datapath read_datapath_assert #(
	.EXTRA_SHIFT (EXTRA_SHIFT)
) read_datapath_assert_i (
	.pll_afi_clk                (pll_afi_clk),
	.reset_n_afi_clk            (reset_n_afi_clk),
	.rdata_en_i                 (rdata_en_i),
	.seq_read_latency_counter_i (seq_read_latency_counter_i),
	.afi_rdata_o                (afi_rdata_o),
	.afi_rdata_valid_o          (afi_rdata_valid_o),
	.force_oct_off_o            (force_oct_off_o)
);

`default_nettype wire

// File: verilog/read_datapath.sv
/*
 * Read datapath, AFI clock side
 * Latency-aligned pop of the per-group read FIFOs, beat merge and
 * reordering, and the termination force-off level
 */

`timescale 1ns/100ps
`default_nettype none

module read_datapath #(
	parameter int EXTRA_SHIFT      = 1,
	parameter int MAX_READ_LATENCY = 16,
	parameter int READ_FIFO_DEPTH  = 8,
	parameter int MEM_T_RL         = 11
) (
	input  wire                        pll_afi_clk,
	input  wire                        reset_n_afi_clk,
	input  wire                        rdata_en_i,
	input  read_path_pkg::lat_count_t  seq_read_latency_counter_i,
	input  read_path_pkg::group_mask_t seq_read_fifo_reset_i,
	input  read_path_pkg::group_mask_t capture_valid_i,
	input  read_path_pkg::afi_data_t   capture_data_i,
	output read_path_pkg::afi_data_t   afi_rdata_o,
	output read_path_pkg::afi_data_t   seq_rdata_o,
	output logic                       afi_rdata_valid_o,
	output logic                       force_oct_off_o
);

	// Width of one group's slice of the capture bus
	localparam int GROUP_DATA_WIDTH = $bits(read_path_pkg::group_data_t);

	// Pop strobe shared by all group FIFOs
	logic read_pop;

	// Popped beat of each group
	read_path_pkg::group_beat_t group_beats [read_path_pkg::NUM_GROUPS];

	// ************************************************************
	// Read latency
	// ************************************************************

	read_latency_fifo #(
		.EXTRA_SHIFT      (EXTRA_SHIFT),
		.MAX_READ_LATENCY (MAX_READ_LATENCY)
	) read_latency_fifo_i (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.rdata_en_i                 (rdata_en_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.read_pop_o                 (read_pop)
	);

	// ************************************************************
	// Per-group read FIFOs
	// ************************************************************

	// Capture bus is in group order, group g starts at bit GROUP_DATA_WIDTH*g
	generate
		for (genvar g = 0; g < read_path_pkg::NUM_GROUPS; g++) begin : g_group_fifo
			group_read_fifo #(
				.READ_FIFO_DEPTH (READ_FIFO_DEPTH)
			) group_read_fifo_i (
				.pll_afi_clk           (pll_afi_clk),
				.reset_n_afi_clk       (reset_n_afi_clk),
				.seq_read_fifo_reset_i (seq_read_fifo_reset_i[g]),
				.capture_valid_i       (capture_valid_i[g]),
				.capture_data_i        (capture_data_i[g*GROUP_DATA_WIDTH +: GROUP_DATA_WIDTH]),
				.read_pop_i            (read_pop),
				.beat_o                (group_beats[g])
			);
		end
	endgenerate

	// ************************************************************
	// Beat merge and termination
	// ************************************************************

	read_data_align read_data_align_i (
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.beats_i           (group_beats),
		.afi_rdata_o       (afi_rdata_o),
		.seq_rdata_o       (seq_rdata_o),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

	// Termination follows the raw read enable, not the latency-shifted one
	oct_control #(
		.MEM_T_RL (MEM_T_RL)
	) oct_control_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_i      (rdata_en_i),
		.force_oct_off_o (force_oct_off_o)
	);

endmodule

`default_nettype wire

// File: verilog/oct_control.sv
/*
 * On-die termination control
 * Forces termination off except in a window around each read burst
 */

`timescale 1ns/100ps
`default_nettype none

module oct_control #(
	parameter int MEM_T_RL = 11
) (
	input  wire  pll_afi_clk,
	input  wire  reset_n_afi_clk,
	input  wire  rdata_en_i,
	output logic force_oct_off_o
);

	// Window edges in AFI cycles after the read enable
	// Termination must be on before the burst and stay on until it has passed
	localparam int OCT_ON_DELAY  = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 4) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 8) / 4;

	// Past read enables, bit k holds the enable from k+1 cycles back
	logic [OCT_OFF_DELAY-1:0] rdata_en_hist;

	// Current enable joined with its history, bit j is the enable j cycles back
	logic [OCT_OFF_DELAY:0] rdata_en_window;

	assign rdata_en_window = {rdata_en_hist, rdata_en_i};

	// ************************************************************
	// Termination window
	// ************************************************************

	// Force-off drops while any enable lies between the on and off delays
	// Reset leaves it low, so termination is not forced off until the first clock
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			rdata_en_hist   <= '0;
			force_oct_off_o <= 1'b0;
		end else begin
			rdata_en_hist   <= rdata_en_window[OCT_OFF_DELAY-1:0];
			force_oct_off_o <= ~(|rdata_en_window[OCT_OFF_DELAY:OCT_ON_DELAY]);
		end
	end

endmodule

`default_nettype wire

// File: verilog/read_data_align.sv
/*
 * Read data alignment
 * Merges popped group beats into one AFI beat, forms read valid and
 * presents the data in time-slot order and in group order
 */

`timescale 1ns/100ps
`default_nettype none

module read_data_align (
	input  wire                        pll_afi_clk,
	input  wire                        reset_n_afi_clk,
	input  read_path_pkg::group_beat_t beats_i [read_path_pkg::NUM_GROUPS],
	output read_path_pkg::afi_data_t   afi_rdata_o,
	output read_path_pkg::afi_data_t   seq_rdata_o,
	output logic                       afi_rdata_valid_o
);

	// Width of one group's beat
	localparam int GROUP_DATA_WIDTH = $bits(read_path_pkg::group_data_t);

	// Valid bit of every group beat, gathered into one vector
	read_path_pkg::group_mask_t group_valid;

	// Registered group words, still in group order
	read_path_pkg::group_data_t group_data_q [read_path_pkg::NUM_GROUPS];

	// ************************************************************
	// Valid merge
	// ************************************************************

	always_comb begin
		for (int g = 0; g < read_path_pkg::NUM_GROUPS; g++) begin
			group_valid[g] = beats_i[g].valid;
		end
	end

	// A beat counts only when every group delivered a word at the same pop
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid_o <= 1'b0;
		end else begin
			afi_rdata_valid_o <= &group_valid;
		end
	end

	// Data travels alongside valid, so it is sampled every cycle
	always_ff @(posedge pll_afi_clk) begin
		for (int g = 0; g < read_path_pkg::NUM_GROUPS; g++) begin
			group_data_q[g] <= beats_i[g].data;
		end
	end

	// ************************************************************
	// Data reordering
	// ************************************************************

	// Controller bus is ordered by time slot, then by group within the slot
	// Sequencer bus keeps group order with slots inside each group
	generate
		for (genvar g = 0; g < read_path_pkg::NUM_GROUPS; g++) begin : g_group
			for (genvar t = 0; t < read_path_pkg::SLOTS_PER_BEAT; t++) begin : g_slot
				assign afi_rdata_o[t*read_path_pkg::MEM_DQ_WIDTH +
						g*read_path_pkg::DQ_GROUP_WIDTH +: read_path_pkg::DQ_GROUP_WIDTH] =
						group_data_q[g][t*read_path_pkg::DQ_GROUP_WIDTH +:
						read_path_pkg::DQ_GROUP_WIDTH];
			end

			assign seq_rdata_o[g*GROUP_DATA_WIDTH +: GROUP_DATA_WIDTH] = group_data_q[g];
		end
	endgenerate

endmodule

`default_nettype wire

// File: verilog/group_read_fifo.sv
/*
 * Group read FIFO
 * Buffers captured read words of one DQS group until the latency pop arrives
 */

`timescale 1ns/100ps
`default_nettype none

module group_read_fifo #(
	parameter int READ_FIFO_DEPTH = 8
) (
	input  wire                        pll_afi_clk,
	input  wire                        reset_n_afi_clk,
	input  wire                        seq_read_fifo_reset_i,
	input  wire                        capture_valid_i,
	input  read_path_pkg::group_data_t capture_data_i,
	input  wire                        read_pop_i,
	output read_path_pkg::group_beat_t beat_o
);

	// Pointers carry one extra wrap bit to tell full from empty
	localparam int ADDR_WIDTH = $clog2(READ_FIFO_DEPTH);

	// Sequencer reset after its register stage
	logic fifo_reset_q;

	logic [ADDR_WIDTH:0] wr_ptr;
	logic [ADDR_WIDTH:0] rd_ptr;

	// Storage for captured words
	read_path_pkg::group_data_t fifo_mem [READ_FIFO_DEPTH];

	logic fifo_empty;
	logic fifo_full;
	logic do_write;
	logic do_read;

	// Output beat registers
	logic                       beat_valid_q;
	read_path_pkg::group_data_t beat_data_q;

	// ************************************************************
	// Sequencer reset
	// ************************************************************

	// The calibration reset is registered once before it touches the pointers
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			fifo_reset_q <= 1'b0;
		end else begin
			fifo_reset_q <= seq_read_fifo_reset_i;
		end
	end

	// ************************************************************
	// Pointers and flags
	// ************************************************************

	// The registered reset makes the FIFO look empty at once, even before
	// the pointers have been cleared
	assign fifo_empty = (wr_ptr == rd_ptr) || fifo_reset_q;
	assign fifo_full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
			(wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

	// A capture into a full FIFO is lost, there is no back-pressure
	assign do_write = capture_valid_i && !fifo_full && !fifo_reset_q;

	// A pop on an empty FIFO leaves the pointers alone
	assign do_read = read_pop_i && !fifo_empty;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (fifo_reset_q) begin
			// Held empty while the sequencer keeps its reset asserted
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// ************************************************************
	// Storage and output beat
	// ************************************************************

	always_ff @(posedge pll_afi_clk) begin
		if (do_write) begin
			fifo_mem[wr_ptr[ADDR_WIDTH-1:0]] <= capture_data_i;
		end
	end

	// Valid follows every pop and is low when the FIFO had nothing to give
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			beat_valid_q <= 1'b0;
		end else begin
			beat_valid_q <= do_read;
		end
	end

	// Head word is taken on a successful pop only
	always_ff @(posedge pll_afi_clk) begin
		if (do_read) begin
			beat_data_q <= fifo_mem[rd_ptr[ADDR_WIDTH-1:0]];
		end
	end

	assign beat_o.valid = beat_valid_q;
	assign beat_o.data  = beat_data_q;

endmodule

`default_nettype wire

// File: verilog/read_latency_fifo.sv
/*
 * Read latency FIFO
 * Delays the controller read enable by an optional extra shift and a
 * sequencer-selected latency, and issues the pop strobe for the group FIFOs
 */

`timescale 1ns/100ps
`default_nettype none

module read_latency_fifo #(
	parameter int EXTRA_SHIFT      = 1,
	parameter int MAX_READ_LATENCY = 16
) (
	input  wire                       pll_afi_clk,
	input  wire                       reset_n_afi_clk,
	input  wire                       rdata_en_i,
	input  read_path_pkg::lat_count_t seq_read_latency_counter_i,
	output logic                      read_pop_o
);

	// Read enable after the optional extra delay
	logic rdata_en_int;

	// Enable history, bit k holds the enable from k+1 cycles back
	logic [MAX_READ_LATENCY-1:0] latency_shifter;

	// ************************************************************
	// Extra read-enable shift
	// ************************************************************

	// Adds EXTRA_SHIFT whole AFI cycles in front of the latency shifter
	generate
		if (EXTRA_SHIFT >= 1) begin : g_extra_shift
			logic [EXTRA_SHIFT-1:0] extra_shift_q;
			logic [EXTRA_SHIFT:0]   extra_shift_next;

			// The new enable enters at bit 0 and leaves from the top bit
			assign extra_shift_next = {extra_shift_q, rdata_en_i};

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
				if (!reset_n_afi_clk) begin
					extra_shift_q <= '0;
				end else begin
					extra_shift_q <= extra_shift_next[EXTRA_SHIFT-1:0];
				end
			end

			assign rdata_en_int = extra_shift_q[EXTRA_SHIFT-1];
		end else begin : g_no_extra_shift
			// No extra delay, the enable feeds the latency shifter straight away
			assign rdata_en_int = rdata_en_i;
		end
	endgenerate

	// ************************************************************
	// Latency shifter and tap selector
	// ************************************************************

	// One new enable per AFI cycle, oldest at the top
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			latency_shifter <= '0;
		end else begin
			latency_shifter <= {latency_shifter[MAX_READ_LATENCY-2:0], rdata_en_int};
		end
	end

	// The counter names the tap, so calibration moves the pop by whole AFI cycles
	// Tap L is L+1 deep and the selector flop adds one more cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			read_pop_o <= 1'b0;
		end else begin
			read_pop_o <= latency_shifter[seq_read_latency_counter_i];
		end
	end

endmodule

`default_nettype wire

// File: verilog/read_path_pkg.sv
/*
 * Read datapath shared definitions
 * Group and beat widths, latency counter width and the popped group beat record
 */

`default_nettype none

package read_path_pkg;

	// ************************************************************
	// Geometry of the read interface
	// ************************************************************

	// Number of read DQS groups on the interface
	localparam int NUM_GROUPS = 2;

	// DQ bits carried by one DQS group
	localparam int DQ_GROUP_WIDTH = 8;

	// Full-rate interface, so one AFI beat holds the rising and falling time slot
	localparam int SLOTS_PER_BEAT = 2;

	// Total DQ width of the memory interface
	localparam int MEM_DQ_WIDTH = NUM_GROUPS * DQ_GROUP_WIDTH;

	// Width of the sequencer latency counter
	localparam int LAT_COUNT_WIDTH = 4;

	// ************************************************************
	// Vector types
	// ************************************************************

	// One group's beat, slot t sits at bit DQ_GROUP_WIDTH*t upward
	typedef logic [SLOTS_PER_BEAT*DQ_GROUP_WIDTH-1:0] group_data_t;

	// One full beat across every group
	typedef logic [SLOTS_PER_BEAT*MEM_DQ_WIDTH-1:0] afi_data_t;

	// One bit per DQS group
	typedef logic [NUM_GROUPS-1:0] group_mask_t;

	// Read latency selected by the sequencer, in AFI cycles
	typedef logic [LAT_COUNT_WIDTH-1:0] lat_count_t;

	// A beat popped from one group FIFO
	// Valid is low when the pop found the FIFO empty
	typedef struct packed {
		logic        valid;
		group_data_t data;
	} group_beat_t;

endpackage

`default_nettype wire
